// ==== design/mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// byte address width seen by the core
`define ADDR_W 32

// bus and register word width
`define DATA_W 32

// data_ram depth, counted in words
// byte addresses stay below 4 * `RAM_WORDS
`define RAM_WORDS 256

`endif

// ==== design/lsu_pkg.sv ====
`include "mem_macros.svh"

package lsu_pkg;

  // byte address as issued by the core
  typedef logic [`ADDR_W-1:0] addr_t;

  typedef logic [`DATA_W-1:0] word_t;

  // fetched instruction word
  typedef logic [`DATA_W-1:0] instr_t;

  // one enable per byte lane
  typedef logic [`DATA_W/8-1:0] strb_t;

  // load functions, signed or unsigned narrow loads and full word
  typedef enum logic [2:0] {
    LD_BS = 3'd0,
    LD_BU = 3'd1,
    LD_HS = 3'd2,
    LD_HU = 3'd3,
    LD_W  = 3'd4
  } ld_func_e;

  typedef enum logic [2:0] {
    ST_B = 3'd0,
    ST_H = 3'd1,
    ST_W = 3'd2
  } st_func_e;

endpackage

// ==== design/bus_pkg.sv ====
package bus_pkg;

  // owner of an access on the shared memory bus
  typedef enum logic {
    REQ_LSU   = 1'b0,
    REQ_FETCH = 1'b1
  } req_id_e;

  // one request carries either a read or a full write
  typedef struct packed {
    logic           we;
    // word index, byte address shifted right by two
    lsu_pkg::addr_t addr;
    // already placed on the addressed lanes
    lsu_pkg::word_t wdata;
    lsu_pkg::strb_t strb;
  } mem_req_t;

  // writes return one too, data is don't care then
  typedef struct packed {
    lsu_pkg::word_t rdata;
  } mem_rsp_t;

endpackage

// ==== design/lsu.sv ====
module lsu (
  input  logic              clk,
  input  logic              rstn,
  input  lsu_pkg::addr_t    raddr,
  input  lsu_pkg::ld_func_e rfunc,
  input  logic              rreq_valid,
  output logic              rreq_ready,
  output lsu_pkg::word_t    rdata,
  output logic              rres_valid,
  input  logic              rres_ready,
  input  lsu_pkg::addr_t    waddr,
  input  lsu_pkg::st_func_e wfunc,
  input  lsu_pkg::word_t    wdata,
  input  logic              wreq_valid,
  output logic              wreq_ready,
  output logic              wres_valid,
  input  logic              wres_ready,
  output bus_pkg::mem_req_t bus_req,
  output logic              bus_req_valid,
  input  logic              bus_req_ready,
  input  bus_pkg::mem_rsp_t bus_rsp,
  input  logic              bus_rsp_valid,
  output logic              bus_rsp_ready
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT_READ,
    S_WAIT_WRITE
  } state_e;

  state_e            state;
  logic              sel_locked;
  logic              sel_write_q;
  logic              sel_write;
  logic              req_fire;
  logic              rsp_fire;
  logic [1:0]        roff_q;
  lsu_pkg::ld_func_e rfunc_q;
  lsu_pkg::strb_t    wmask;
  lsu_pkg::word_t    rdata_shifted;

  // write wins a tie, a stalled request keeps its port until taken
  assign sel_write     = sel_locked ? sel_write_q : wreq_valid;
  assign bus_req_valid = (state == S_IDLE) && (wreq_valid || rreq_valid);
  assign wreq_ready    = (state == S_IDLE) && sel_write && bus_req_ready;
  assign rreq_ready    = (state == S_IDLE) && !sel_write && bus_req_ready;
  assign req_fire      = bus_req_valid && bus_req_ready;

  // unaligned mask, lane 0 based
  always_comb begin
    case (wfunc)
      lsu_pkg::ST_B: wmask = 4'b0001;
      lsu_pkg::ST_H: wmask = 4'b0011;
      default:       wmask = 4'b1111;
    endcase
  end

  always_comb begin
    if (sel_write) begin
      bus_req.we    = 1'b1;
      bus_req.addr  = {2'b00, waddr[31:2]};
      bus_req.wdata = wdata << {waddr[1:0], 3'b000};
      bus_req.strb  = wmask << waddr[1:0];
    end else begin
      bus_req.we    = 1'b0;
      bus_req.addr  = {2'b00, raddr[31:2]};
      bus_req.wdata = '0;
      bus_req.strb  = '0;
    end
  end

  // move the addressed bytes down to lane 0
  assign rdata_shifted = bus_rsp.rdata >> {roff_q, 3'b000};

  always_comb begin
    case (rfunc_q)
      lsu_pkg::LD_BS: rdata = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
      lsu_pkg::LD_BU: rdata = {24'b0, rdata_shifted[7:0]};
      lsu_pkg::LD_HS: rdata = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
      lsu_pkg::LD_HU: rdata = {16'b0, rdata_shifted[15:0]};
      default:        rdata = rdata_shifted;
    endcase
  end

  // response goes to whichever port issued the access
  assign rres_valid    = (state == S_WAIT_READ) && bus_rsp_valid;
  assign wres_valid    = (state == S_WAIT_WRITE) && bus_rsp_valid;
  assign bus_rsp_ready = ((state == S_WAIT_READ) && rres_ready) ||
                         ((state == S_WAIT_WRITE) && wres_ready);
  assign rsp_fire      = bus_rsp_valid && bus_rsp_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state       <= S_IDLE;
      sel_locked  <= 1'b0;
      sel_write_q <= 1'b0;
    end else begin
      sel_locked  <= bus_req_valid && !bus_req_ready;
      sel_write_q <= sel_write;
      case (state)
        S_IDLE: begin
          if (req_fire) begin
            state <= sel_write ? S_WAIT_WRITE : S_WAIT_READ;
          end
        end
        S_WAIT_READ, S_WAIT_WRITE: begin
          if (rsp_fire) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // load context for the returning word
  always_ff @(posedge clk) begin
    if (rreq_valid && rreq_ready) begin
      roff_q  <= raddr[1:0];
      rfunc_q <= rfunc;
    end
  end

  a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
    bus_req_valid && !bus_req_ready |=> bus_req_valid && $stable(bus_req))
    else $error("lsu bus request changed while stalled");

endmodule

// ==== design/fetch_unit.sv ====
module fetch_unit (
  input  logic              clk,
  input  logic              rstn,
  input  logic              start,
  input  lsu_pkg::addr_t    start_pc,
  input  logic [7:0]        fetch_count,
  output logic              busy,
  output lsu_pkg::instr_t   instr,
  output logic              instr_valid,
  input  logic              instr_ready,
  output bus_pkg::mem_req_t bus_req,
  output logic              bus_req_valid,
  input  logic              bus_req_ready,
  input  bus_pkg::mem_rsp_t bus_rsp,
  input  logic              bus_rsp_valid,
  output logic              bus_rsp_ready
);

  typedef enum logic [1:0] {
    F_IDLE,
    F_REQ,
    F_WAIT
  } state_e;

  state_e         state;
  lsu_pkg::addr_t pc;
  logic [7:0]     remaining;

  assign busy          = (state != F_IDLE);
  assign bus_req_valid = (state == F_REQ);
  assign bus_req.we    = 1'b0;
  assign bus_req.addr  = {2'b00, pc[31:2]};
  assign bus_req.wdata = '0;
  assign bus_req.strb  = '0;

  // instruction port mirrors the bus response
  assign instr         = bus_rsp.rdata;
  assign instr_valid   = (state == F_WAIT) && bus_rsp_valid;
  assign bus_rsp_ready = (state == F_WAIT) && instr_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= F_IDLE;
      remaining <= '0;
    end else begin
      case (state)
        F_IDLE: begin
          // a zero count leaves the unit idle
          if (start && (fetch_count != 8'd0)) begin
            state     <= F_REQ;
            remaining <= fetch_count;
          end
        end
        F_REQ: begin
          if (bus_req_ready) begin
            state     <= F_WAIT;
            remaining <= remaining - 8'd1;
          end
        end
        F_WAIT: begin
          if (bus_rsp_valid && instr_ready) begin
            state <= (remaining == 8'd0) ? F_IDLE : F_REQ;
          end
        end
        default: state <= F_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == F_IDLE) && start) begin
      pc <= start_pc;
    end else if (bus_req_valid && bus_req_ready) begin
      pc <= pc + 32'd4;
    end
  end

endmodule

// ==== design/mem_arbiter.sv ====
module mem_arbiter (
  input  logic              clk,
  input  logic              rstn,
  input  bus_pkg::mem_req_t lsu_req,
  input  logic              lsu_req_valid,
  output logic              lsu_req_ready,
  output bus_pkg::mem_rsp_t lsu_rsp,
  output logic              lsu_rsp_valid,
  input  logic              lsu_rsp_ready,
  input  bus_pkg::mem_req_t fetch_req,
  input  logic              fetch_req_valid,
  output logic              fetch_req_ready,
  output bus_pkg::mem_rsp_t fetch_rsp,
  output logic              fetch_rsp_valid,
  input  logic              fetch_rsp_ready,
  output bus_pkg::mem_req_t ram_req,
  output logic              ram_req_valid,
  input  logic              ram_req_ready,
  input  bus_pkg::mem_rsp_t ram_rsp,
  input  logic              ram_rsp_valid,
  output logic              ram_rsp_ready
);

  typedef enum logic {
    A_IDLE,
    A_PENDING
  } state_e;

  state_e           state;
  bus_pkg::req_id_e last_grant;
  bus_pkg::req_id_e owner;
  logic             gnt_fetch;
  logic             to_lsu;

  // fetch wins only alone or when the lsu had the previous grant
  assign gnt_fetch = fetch_req_valid && (!lsu_req_valid || (last_grant == bus_pkg::REQ_LSU));

  assign ram_req         = gnt_fetch ? fetch_req : lsu_req;
  assign ram_req_valid   = (state == A_IDLE) && (lsu_req_valid || fetch_req_valid);
  assign lsu_req_ready   = (state == A_IDLE) && !gnt_fetch && ram_req_ready;
  assign fetch_req_ready = (state == A_IDLE) && gnt_fetch && ram_req_ready;

  // responses only reach the recorded owner
  assign to_lsu          = (owner == bus_pkg::REQ_LSU);
  assign lsu_rsp         = ram_rsp;
  assign fetch_rsp       = ram_rsp;
  assign lsu_rsp_valid   = (state == A_PENDING) && to_lsu && ram_rsp_valid;
  assign fetch_rsp_valid = (state == A_PENDING) && !to_lsu && ram_rsp_valid;
  assign ram_rsp_ready   = (state == A_PENDING) && (to_lsu ? lsu_rsp_ready : fetch_rsp_ready);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= A_IDLE;
      owner      <= bus_pkg::REQ_LSU;
      // so that the lsu takes the first tie
      last_grant <= bus_pkg::REQ_FETCH;
    end else begin
      case (state)
        A_IDLE: begin
          if (ram_req_valid && ram_req_ready) begin
            state      <= A_PENDING;
            owner      <= gnt_fetch ? bus_pkg::REQ_FETCH : bus_pkg::REQ_LSU;
            last_grant <= gnt_fetch ? bus_pkg::REQ_FETCH : bus_pkg::REQ_LSU;
          end
        end
        A_PENDING: begin
          if (ram_rsp_valid && ram_rsp_ready) begin
            state <= A_IDLE;
          end
        end
        default: state <= A_IDLE;
      endcase
    end
  end

  a_single_outstanding: assert property (@(posedge clk) disable iff (!rstn)
    ram_req_valid && ram_req_ready |=>
      !ram_req_valid until_with (ram_rsp_valid && ram_rsp_ready))
    else $error("second grant issued while a response is pending");

endmodule

// ==== design/data_ram.sv ====
`include "mem_macros.svh"

module data_ram (
  input  logic              clk,
  input  logic              rstn,
  input  bus_pkg::mem_req_t req,
  input  logic              req_valid,
  output logic              req_ready,
  output bus_pkg::mem_rsp_t rsp,
  output logic              rsp_valid,
  input  logic              rsp_ready
);

  localparam int IDX_W = $clog2(`RAM_WORDS);

  lsu_pkg::word_t   mem [`RAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             req_fire;

  assign idx       = req.addr[IDX_W-1:0];
  // free slot or the held response leaves this cycle
  assign req_ready = !rsp_valid || rsp_ready;
  assign req_fire  = req_valid && req_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rsp_valid <= 1'b0;
    end else if (req_fire) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // old word is returned on a write as well
  always_ff @(posedge clk) begin
    if (req_fire) begin
      rsp.rdata <= mem[idx];
      if (req.we) begin
        for (int i = 0; i < `DATA_W / 8; i++) begin
          if (req.strb[i]) begin
            mem[idx][i*8 +: 8] <= req.wdata[i*8 +: 8];
          end
        end
      end
    end
  end

  a_addr_range: assert property (@(posedge clk) disable iff (!rstn)
    req_valid |-> (req.addr < `RAM_WORDS))
    else $error("data_ram word address out of range");

endmodule

// ==== design/mem_top.sv ====
module mem_top (
  input  logic              clk,
  input  logic              rstn,
  input  lsu_pkg::addr_t    raddr,
  input  lsu_pkg::ld_func_e rfunc,
  input  logic              rreq_valid,
  output logic              rreq_ready,
  output lsu_pkg::word_t    rdata,
  output logic              rres_valid,
  input  logic              rres_ready,
  input  lsu_pkg::addr_t    waddr,
  input  lsu_pkg::st_func_e wfunc,
  input  lsu_pkg::word_t    wdata,
  input  logic              wreq_valid,
  output logic              wreq_ready,
  output logic              wres_valid,
  input  logic              wres_ready,
  input  logic              start,
  input  lsu_pkg::addr_t    start_pc,
  input  logic [7:0]        fetch_count,
  output logic              busy,
  output lsu_pkg::instr_t   instr,
  output logic              instr_valid,
  input  logic              instr_ready
);

  bus_pkg::mem_req_t lsu_req, fetch_req, ram_req;
  bus_pkg::mem_rsp_t lsu_rsp, fetch_rsp, ram_rsp;
  logic              lsu_req_valid, lsu_req_ready, lsu_rsp_valid, lsu_rsp_ready;
  logic              fetch_req_valid, fetch_req_ready, fetch_rsp_valid, fetch_rsp_ready;
  logic              ram_req_valid, ram_req_ready, ram_rsp_valid, ram_rsp_ready;

  lsu i_lsu (
    .clk, .rstn, .raddr, .rfunc, .rreq_valid, .rreq_ready, .rdata, .rres_valid,
    .rres_ready, .waddr, .wfunc, .wdata, .wreq_valid, .wreq_ready, .wres_valid,
    .wres_ready, .bus_req(lsu_req), .bus_req_valid(lsu_req_valid),
    .bus_req_ready(lsu_req_ready), .bus_rsp(lsu_rsp), .bus_rsp_valid(lsu_rsp_valid),
    .bus_rsp_ready(lsu_rsp_ready)
  );

  fetch_unit i_fetch_unit (
    .clk, .rstn, .start, .start_pc, .fetch_count, .busy, .instr, .instr_valid,
    .instr_ready, .bus_req(fetch_req), .bus_req_valid(fetch_req_valid),
    .bus_req_ready(fetch_req_ready), .bus_rsp(fetch_rsp),
    .bus_rsp_valid(fetch_rsp_valid), .bus_rsp_ready(fetch_rsp_ready)
  );

  mem_arbiter i_mem_arbiter (
    .clk, .rstn, .lsu_req, .lsu_req_valid, .lsu_req_ready, .lsu_rsp, .lsu_rsp_valid,
    .lsu_rsp_ready, .fetch_req, .fetch_req_valid, .fetch_req_ready, .fetch_rsp,
    .fetch_rsp_valid, .fetch_rsp_ready, .ram_req, .ram_req_valid, .ram_req_ready,
    .ram_rsp, .ram_rsp_valid, .ram_rsp_ready
  );

  data_ram i_data_ram (
    .clk, .rstn, .req(ram_req), .req_valid(ram_req_valid), .req_ready(ram_req_ready),
    .rsp(ram_rsp), .rsp_valid(ram_rsp_valid), .rsp_ready(ram_rsp_ready)
  );

endmodule

// ==== verif/tb_mem_top.sv ====
`include "mem_macros.svh"

module tb_mem_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 200;

  typedef enum logic [1:0] {
    OP_STORE,
    OP_LOAD,
    OP_FETCH
  } op_kind_e;

  // one table row
  typedef struct packed {
    op_kind_e       kind;
    logic [2:0]     func;
    lsu_pkg::addr_t addr;
    // word count for a fetch
    lsu_pkg::word_t data;
    lsu_pkg::word_t expected;
  } op_t;

  logic              clk = 1'b0;
  logic              rstn;
  lsu_pkg::addr_t    raddr;
  lsu_pkg::ld_func_e rfunc;
  logic              rreq_valid;
  logic              rreq_ready;
  lsu_pkg::word_t    rdata;
  logic              rres_valid;
  logic              rres_ready;
  lsu_pkg::addr_t    waddr;
  lsu_pkg::st_func_e wfunc;
  lsu_pkg::word_t    wdata;
  logic              wreq_valid;
  logic              wreq_ready;
  logic              wres_valid;
  logic              wres_ready;
  logic              start;
  lsu_pkg::addr_t    start_pc;
  logic [7:0]        fetch_count;
  logic              busy;
  lsu_pkg::instr_t   instr;
  logic              instr_valid;
  logic              instr_ready;

  // byte image of what the RAM should hold
  logic [7:0]        ref_bytes [0:4*`RAM_WORDS-1];
  op_t               ops [$];
  lsu_pkg::instr_t   instr_exp [$];
  logic [31:0]       rng = 32'hdf8b;
  logic [31:0]       instr_rng;
  logic              timed_out = 1'b0;
  int                load_errors = 0;
  int                instr_errors = 0;
  int                protocol_errors = 0;
  int                timeout_errors = 0;
  // loads that finish while the fetch still runs
  int                shared_loads = 0;

  mem_top i_dut (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic lsu_pkg::word_t ref_word(input lsu_pkg::addr_t a);
    return {ref_bytes[a+3], ref_bytes[a+2], ref_bytes[a+1], ref_bytes[a]};
  endfunction

  // addressed bytes moved to lane 0, then extended
  function automatic lsu_pkg::word_t predict_load(input lsu_pkg::addr_t a,
                                                  input lsu_pkg::ld_func_e f);
    logic [7:0] b0;
    logic [7:0] b1;
    b0 = ref_bytes[a];
    b1 = ref_bytes[a+1];
    case (f)
      lsu_pkg::LD_BS: return {{24{b0[7]}}, b0};
      lsu_pkg::LD_BU: return {24'h0, b0};
      lsu_pkg::LD_HS: return {{16{b1[7]}}, b1, b0};
      lsu_pkg::LD_HU: return {16'h0, b1, b0};
      default:        return ref_word(a);
    endcase
  endfunction

  task automatic check_load(input lsu_pkg::addr_t a, input lsu_pkg::word_t got,
                            input lsu_pkg::word_t exp);
    if (got !== exp) begin
      load_errors++;
      $display("FAIL %0t: load from %h returned %h, expected %h", $time, a, got, exp);
    end
  endtask

  task automatic check_instr(input lsu_pkg::instr_t got, input lsu_pkg::instr_t exp);
    if (got !== exp) begin
      instr_errors++;
      $display("FAIL %0t: instruction %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_idle(input string name, input logic got);
    if (got !== 1'b0) begin
      protocol_errors++;
      $display("FAIL %0t: %s is not low after reset", $time, name);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_errors++;
    timed_out = 1'b1;
    $display("ERROR %0t: timed out waiting for %s", $time, what);
  endtask

  task automatic record_store(input lsu_pkg::addr_t a, input lsu_pkg::st_func_e f,
                              input lsu_pkg::word_t d);
    op_t op;
    op.kind     = OP_STORE;
    op.func     = f;
    op.addr     = a;
    op.data     = d;
    op.expected = '0;
    ref_bytes[a] = d[7:0];
    if (f != lsu_pkg::ST_B) begin
      ref_bytes[a+1] = d[15:8];
    end
    if (f == lsu_pkg::ST_W) begin
      ref_bytes[a+2] = d[23:16];
      ref_bytes[a+3] = d[31:24];
    end
    ops.push_back(op);
  endtask

  task automatic record_load(input lsu_pkg::addr_t a, input lsu_pkg::ld_func_e f);
    op_t op;
    op.kind     = OP_LOAD;
    op.func     = f;
    op.addr     = a;
    op.data     = '0;
    op.expected = predict_load(a, f);
    ops.push_back(op);
  endtask

  // instructions expected in address order
  task automatic record_fetch(input lsu_pkg::addr_t pc, input int count);
    op_t op;
    op.kind     = OP_FETCH;
    op.func     = '0;
    op.addr     = pc;
    op.data     = count;
    op.expected = '0;
    for (int i = 0; i < count; i++) begin
      instr_exp.push_back(ref_word(pc + 4 * i));
    end
    ops.push_back(op);
  endtask

  task automatic build_table();
    record_store(32'h10, lsu_pkg::ST_W, 32'hdead_beef);
    record_load(32'h10, lsu_pkg::LD_W);
    rng = xorshift32(rng);
    record_store(32'h14, lsu_pkg::ST_W, rng);
    record_load(32'h14, lsu_pkg::LD_W);
    // one byte lane at a time over a known word
    for (int off = 0; off < 4; off++) begin
      rng = xorshift32(rng);
      record_store(32'h40, lsu_pkg::ST_W, 32'h1122_3344);
      record_store(32'h40 + off, lsu_pkg::ST_B, rng);
      record_load(32'h40, lsu_pkg::LD_W);
    end
    for (int off = 0; off < 3; off++) begin
      rng = xorshift32(rng);
      record_store(32'h44, lsu_pkg::ST_W, 32'h5566_7788);
      record_store(32'h44 + off, lsu_pkg::ST_H, rng);
      record_load(32'h44, lsu_pkg::LD_W);
    end
    // negative and positive bytes and halfwords
    record_store(32'h80, lsu_pkg::ST_W, 32'h807f_ff01);
    record_store(32'h84, lsu_pkg::ST_W, 32'h7f80_01ff);
    for (int a = 32'h80; a < 32'h88; a++) begin
      record_load(a, lsu_pkg::LD_BS);
      record_load(a, lsu_pkg::LD_BU);
      if (a % 4 != 3) begin
        record_load(a, lsu_pkg::LD_HS);
        record_load(a, lsu_pkg::LD_HU);
      end
    end
    for (int i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      record_store(32'h100 + 4 * i, lsu_pkg::ST_W, rng);
    end
    // loads run while the fetch shares the bus
    record_fetch(32'h100, 8);
    for (int i = 0; i < 8; i++) begin
      record_load(32'h80 + i, (i % 2) ? lsu_pkg::LD_BS : lsu_pkg::LD_BU);
      record_load(32'h100 + 4 * i, lsu_pkg::LD_W);
    end
  endtask

  task automatic issue_store(input op_t op);
    int   n;
    logic accepted;
    logic done;
    waddr      <= op.addr;
    wfunc      <= lsu_pkg::st_func_e'(op.func);
    wdata      <= op.data;
    wreq_valid <= 1'b1;
    n = 0;
    accepted = 1'b0;
    while (!accepted && n < TIMEOUT) begin
      @(posedge clk);
      n++;
      accepted = wreq_ready;
    end
    wreq_valid <= 1'b0;
    if (!accepted) begin
      report_timeout("store request acceptance");
      return;
    end
    n = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      @(posedge clk);
      n++;
      done = wres_valid && wres_ready;
    end
    if (!done) begin
      report_timeout("store response");
    end
  endtask

  task automatic issue_load(input op_t op);
    int   n;
    logic accepted;
    logic done;
    raddr      <= op.addr;
    rfunc      <= lsu_pkg::ld_func_e'(op.func);
    rreq_valid <= 1'b1;
    n = 0;
    accepted = 1'b0;
    while (!accepted && n < TIMEOUT) begin
      @(posedge clk);
      n++;
      accepted = rreq_ready;
      if (rres_valid) begin
        protocol_errors++;
        $display("ERROR %0t: load response seen with no load outstanding", $time);
      end
    end
    rreq_valid <= 1'b0;
    if (!accepted) begin
      report_timeout("load request acceptance");
      return;
    end
    n = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      @(posedge clk);
      n++;
      // a held response must not change while it waits
      if (rres_valid) begin
        check_load(op.addr, rdata, op.expected);
        done = rres_ready;
        if (done && busy) begin
          shared_loads++;
        end
      end
      rng = xorshift32(rng);
      rres_ready <= rng[0];
    end
    if (!done) begin
      report_timeout("load response");
    end
  endtask

  task automatic start_fetch(input op_t op);
    start_pc    <= op.addr;
    fetch_count <= op.data[7:0];
    start       <= 1'b1;
    @(posedge clk);
    start       <= 1'b0;
  endtask

  task automatic wait_fetch_drain();
    int   n;
    logic idle;
    n = 0;
    idle = 1'b0;
    while (!idle && n < TIMEOUT * 8) begin
      @(posedge clk);
      n++;
      idle = !busy;
    end
    if (!idle) begin
      report_timeout("the fetch to finish");
    end else if (instr_exp.size() != 0) begin
      protocol_errors++;
      $display("ERROR %0t: fetch ended with %0d instructions not delivered",
               $time, instr_exp.size());
    end
  endtask

  // instruction sink with random stalls
  always @(posedge clk) begin
    if (rstn) begin
      if (instr_valid) begin
        if (instr_exp.size() == 0) begin
          protocol_errors++;
          $display("ERROR %0t: extra instruction %h delivered", $time, instr);
        end else begin
          check_instr(instr, instr_exp[0]);
          if (instr_ready) begin
            void'(instr_exp.pop_front());
          end
        end
      end
      instr_rng = xorshift32(instr_rng);
      instr_ready <= instr_rng[2];
    end
  end

  initial begin
    instr_rng = xorshift32(rng);
    rstn        <= 1'b0;
    raddr       <= '0;
    rfunc       <= lsu_pkg::LD_W;
    rreq_valid  <= 1'b0;
    rres_ready  <= 1'b0;
    waddr       <= '0;
    wfunc       <= lsu_pkg::ST_W;
    wdata       <= '0;
    wreq_valid  <= 1'b0;
    wres_ready  <= 1'b1;
    start       <= 1'b0;
    start_pc    <= '0;
    fetch_count <= '0;
    instr_ready <= 1'b0;
    build_table();
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    check_idle("rres_valid", rres_valid);
    check_idle("wres_valid", wres_valid);
    check_idle("instr_valid", instr_valid);
    check_idle("busy", busy);
    for (int i = 0; i < ops.size(); i++) begin
      case (ops[i].kind)
        OP_STORE: issue_store(ops[i]);
        OP_LOAD:  issue_load(ops[i]);
        default:  start_fetch(ops[i]);
      endcase
      if (timed_out) begin
        break;
      end
    end
    // with alternating grants the fetch ends before the load stream does
    if (!timed_out && (busy || shared_loads == 0)) begin
      protocol_errors++;
      $display("ERROR %0t: fetch and loads did not take turns on the bus", $time);
    end
    wait_fetch_drain();
    $display("errors: load %0d, instr %0d, protocol %0d, timeout %0d",
             load_errors, instr_errors, protocol_errors, timeout_errors);
    if (load_errors + instr_errors + protocol_errors + timeout_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+design
design/lsu_pkg.sv
design/bus_pkg.sv
design/lsu.sv
design/fetch_unit.sv
design/mem_arbiter.sv
design/data_ram.sv
design/mem_top.sv
verif/tb_mem_top.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

export_include_dirs:
  - design

sources:
  - files:
      - design/lsu_pkg.sv
      - design/bus_pkg.sv
      - design/lsu.sv
      - design/fetch_unit.sv
      - design/mem_arbiter.sv
      - design/data_ram.sv
      - design/mem_top.sv
  - target: simulation
    files:
      - verif/tb_mem_top.sv
